// File: rtl/cpu_pkg.sv
/*
 * CPU front-end package
 * Word and field types, instruction field positions, reset vector,
 * PC step, bubble encoding and opcode values of the 32-bit ISA
 */

package cpu_pkg;

    // Basic data types
    typedef logic [31:0] word_t;               // Instruction or address
    typedef logic [5:0]  op_t;                 // Opcode
    typedef logic [4:0]  reg_idx_t;            // Register index
    typedef logic [15:0] imm_t;                // Raw immediate

    // Instruction field positions
    localparam int OP_MSB  = 31;               // Opcode field
    localparam int OP_LSB  = 26;
    localparam int RD_MSB  = 25;               // Destination register
    localparam int RD_LSB  = 21;
    localparam int RS1_MSB = 20;               // First source register
    localparam int RS1_LSB = 16;
    localparam int RS2_MSB = 15;               // Second source register
    localparam int RS2_LSB = 11;
    localparam int IMM_MSB = 15;               // Immediate, overlaps rs2
    localparam int IMM_LSB = 0;

    // Program counter
    localparam word_t RESET_VECTOR = 32'h0000_e100; // First fetch address
    localparam word_t INSN_STEP    = 32'd4;         // One word per instruction

    // Bubble inserted on a discarded word
    localparam word_t ISA_NOP = 32'h0000_0000;

    // Opcode map
    localparam op_t OP_NOP  = 6'd0;            // No operation
    localparam op_t OP_ADD  = 6'd1;            // Register add
    localparam op_t OP_ADDI = 6'd2;            // Add immediate
    localparam op_t OP_LW   = 6'd3;            // Load word
    localparam op_t OP_SW   = 6'd4;            // Store word
    localparam op_t OP_BEQ  = 6'd5;            // Branch if equal
    localparam op_t OP_BNE  = 6'd6;            // Branch if not equal
    localparam op_t OP_JMP  = 6'd7;            // Unconditional jump

    // Anything above OP_JMP decodes as illegal

endpackage

// File: rtl/if_fetch.sv
/*
 * Instruction fetch master
 * Issues one Wishbone classic read per instruction at the current
 * fetch address, captures the word on ack and holds it with data_rdy
 * until the IF/ID register consumes it
 */

`timescale 1ns/1ns

module if_fetch (
    input  logic            clk,        // Clock
    input  logic            rst_n,      // Sync reset, active low
    // IF/ID side
    input  cpu_pkg::word_t  fetch_addr, // Next PC from IF/ID
    input  logic            consume,    // Held word taken this cycle
    // Wishbone classic read master
    output logic            wb_cyc,     // Bus cycle
    output logic            wb_stb,     // Strobe
    output cpu_pkg::word_t  wb_adr,     // Read address
    input  cpu_pkg::word_t  wb_dat,     // Read data
    input  logic            wb_ack,     // Slave acknowledge
    // Fetched word
    output cpu_pkg::word_t  insn,       // Held instruction
    output logic            data_rdy    // Held word valid
);

    // Fetch FSM states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,                 // Latch address, start cycle
        ST_BUS  = 2'd1,                 // Waiting for ack
        ST_HOLD = 2'd2                  // Word held for IF/ID
    } state_t;

    state_t state;                      // Current FSM state

    // Control path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            data_rdy <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    wb_cyc <= 1'b1;     // cyc and stb rise together
                    wb_stb <= 1'b1;
                    state  <= ST_BUS;
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        wb_cyc   <= 1'b0;   // Drop in the cycle after ack
                        wb_stb   <= 1'b0;
                        data_rdy <= 1'b1;   // Word available next cycle
                        state    <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (consume) begin
                        data_rdy <= 1'b0;
                        state    <= ST_IDLE;  // Next PC is settled by now
                    end
                end
                default: begin
                    wb_cyc   <= 1'b0;
                    wb_stb   <= 1'b0;
                    data_rdy <= 1'b0;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    // Address register
    // Loaded only in idle, so it stays stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            wb_adr <= fetch_addr;       // Uses the PC updated by consume
        end
    end

    // Holding register for the fetched word
    always_ff @(posedge clk) begin
        if (state == ST_BUS && wb_ack) begin
            insn <= wb_dat;             // Data valid with ack
        end
    end

endmodule

// File: rtl/if_reg.sv
/*
 * IF/ID pipeline register
 * Owns the next-PC register, accepts the fetched word when not stalled,
 * and records flush or branch redirects which take effect at the
 * next consume by discarding the held word
 */

`timescale 1ns/1ns

module if_reg (
    input  logic            clk,        // Clock
    input  logic            rst_n,      // Sync reset, active low
    // Fetch side
    input  cpu_pkg::word_t  insn,       // Fetched instruction
    input  logic            data_rdy,   // Fetched word valid
    input  logic            stall,      // Pipeline stall
    // Redirects
    input  logic            flush,      // Flush pulse
    input  cpu_pkg::word_t  new_pc,     // Flush target
    input  logic            br_taken,   // Branch taken pulse
    input  cpu_pkg::word_t  br_addr,    // Branch target
    // Back to fetch
    output cpu_pkg::word_t  fetch_addr, // Next PC
    output logic            consume,    // Word accepted this cycle
    // To decode
    output cpu_pkg::word_t  if_pc_out,  // PC of latched word
    output cpu_pkg::word_t  if_insn,    // Latched instruction
    output logic            if_en       // Pipeline valid mark
);

    logic           redirect;           // Any redirect pulse this cycle
    cpu_pkg::word_t redir_target;       // Target of this cycle's pulse
    logic           redir_pend;         // Redirect waiting for consume
    cpu_pkg::word_t redir_addr;         // Stored redirect target

    assign redirect     = flush | br_taken;
    assign redir_target = flush ? new_pc : br_addr; // Flush wins
    assign consume      = data_rdy & ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_addr <= cpu_pkg::RESET_VECTOR;
            if_en      <= 1'b0;
            redir_pend <= 1'b0;
        end else if (redirect) begin
            if_en <= 1'b0;              // Kill the word in flight to ID
            if (consume) begin
                // Held word is from the old stream, drop it now
                fetch_addr <= redir_target;
                if_insn    <= cpu_pkg::ISA_NOP;
                redir_pend <= 1'b0;
            end else begin
                redir_pend <= 1'b1;     // Apply at next consume
                redir_addr <= redir_target;
            end
        end else if (consume) begin
            if (redir_pend) begin
                fetch_addr <= redir_addr;  // Discard held word
                if_insn    <= cpu_pkg::ISA_NOP;
                if_en      <= 1'b0;
                redir_pend <= 1'b0;
            end else begin
                if_pc_out  <= fetch_addr;
                fetch_addr <= fetch_addr + cpu_pkg::INSN_STEP;
                if_insn    <= insn;
                if_en      <= 1'b1;
            end
        end else if (!stall) begin
            if_en <= 1'b0;              // Bubble, nothing fetched
        end
    end

endmodule

// File: rtl/id_decode.sv
/*
 * Instruction decode stage
 * Slices the instruction fields, sign-extends the immediate, flags
 * branches and illegal opcodes, and registers the result for execute
 */

`timescale 1ns/1ns

module id_decode (
    input  logic               clk,          // Clock
    input  logic               rst_n,        // Sync reset, active low
    input  logic               stall,        // Hold outputs
    input  logic               kill,         // Flush or branch pulse
    // From IF/ID
    input  cpu_pkg::word_t     if_pc_out,    // PC of incoming word
    input  cpu_pkg::word_t     if_insn,      // Incoming instruction
    input  logic               if_en,        // Incoming word valid
    // Decoded outputs
    output cpu_pkg::word_t     id_pc,        // Instruction PC
    output cpu_pkg::op_t       id_op,        // Opcode
    output cpu_pkg::reg_idx_t  id_rd,        // Destination register
    output cpu_pkg::reg_idx_t  id_rs1,       // Source register 1
    output cpu_pkg::reg_idx_t  id_rs2,       // Source register 2
    output cpu_pkg::word_t     id_imm,       // Sign-extended immediate
    output logic               id_is_branch, // BEQ, BNE or JMP
    output logic               id_illegal,   // Opcode out of range
    output logic               id_valid      // Outputs valid
);

    localparam int IMM_W  = $bits(cpu_pkg::imm_t);
    localparam int WORD_W = $bits(cpu_pkg::word_t);

    cpu_pkg::op_t       op;             // Sliced fields
    cpu_pkg::reg_idx_t  rd;
    cpu_pkg::reg_idx_t  rs1;
    cpu_pkg::reg_idx_t  rs2;
    cpu_pkg::imm_t      raw_imm;
    cpu_pkg::word_t     imm_ext;        // Immediate after sign extension
    logic               is_branch;
    logic               illegal;

    // Field extraction
    assign op      = if_insn[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB];
    assign rd      = if_insn[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign rs1     = if_insn[cpu_pkg::RS1_MSB:cpu_pkg::RS1_LSB];
    assign rs2     = if_insn[cpu_pkg::RS2_MSB:cpu_pkg::RS2_LSB];
    assign raw_imm = if_insn[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];
    assign imm_ext = {{(WORD_W - IMM_W){raw_imm[IMM_W-1]}}, raw_imm};

    // Opcode classification
    always_comb begin
        is_branch = 1'b0;
        illegal   = 1'b0;
        case (op)
            cpu_pkg::OP_NOP,
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_ADDI,
            cpu_pkg::OP_LW,
            cpu_pkg::OP_SW: begin
                is_branch = 1'b0;       // Plain ALU or memory op
            end
            cpu_pkg::OP_BEQ,
            cpu_pkg::OP_BNE,
            cpu_pkg::OP_JMP: begin
                is_branch = 1'b1;       // Control transfer
            end
            default: begin
                illegal = 1'b1;         // Above OP_JMP
            end
        endcase
    end

    // Valid mark
    // Kill overrides stall so a held word from the old stream is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (kill) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= if_en;
        end
    end

    // Decoded payload, held under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc        <= if_pc_out;
            id_op        <= op;
            id_rd        <= rd;
            id_rs1       <= rs1;
            id_rs2       <= rs2;
            id_imm       <= imm_ext;
            id_is_branch <= is_branch;
            id_illegal   <= illegal;
        end
    end

endmodule

// File: rtl/fetch_top.sv
/*
 * Instruction front end top level
 * Chains the Wishbone fetch master, the IF/ID register and the decode
 * stage, and forms the decode kill from the redirect pulses
 */

`timescale 1ns/1ns

module fetch_top (
    input  logic               clk,          // Clock
    input  logic               rst_n,        // Sync reset, active low
    // Pipeline control
    input  logic               stall,        // Freeze IF/ID and ID
    input  logic               flush,        // Flush pulse
    input  logic               br_taken,     // Branch taken pulse
    input  cpu_pkg::word_t     new_pc,       // Flush target
    input  cpu_pkg::word_t     br_addr,      // Branch target
    // Wishbone classic read master
    output logic               wb_cyc,
    output logic               wb_stb,
    output cpu_pkg::word_t     wb_adr,
    input  cpu_pkg::word_t     wb_dat,
    input  logic               wb_ack,
    // Decoded outputs
    output cpu_pkg::word_t     id_pc,
    output cpu_pkg::op_t       id_op,
    output cpu_pkg::reg_idx_t  id_rd,
    output cpu_pkg::reg_idx_t  id_rs1,
    output cpu_pkg::reg_idx_t  id_rs2,
    output cpu_pkg::word_t     id_imm,
    output logic               id_is_branch,
    output logic               id_illegal,
    output logic               id_valid
);

    cpu_pkg::word_t insn;               // Fetch to IF/ID
    logic           data_rdy;
    cpu_pkg::word_t fetch_addr;         // IF/ID to fetch
    logic           consume;
    cpu_pkg::word_t if_pc_out;          // IF/ID to ID
    cpu_pkg::word_t if_insn;
    logic           if_en;
    logic           kill;               // Any redirect pulse

    assign kill = flush | br_taken;

    if_fetch i_if_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_addr (fetch_addr),
        .consume    (consume),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .insn       (insn),
        .data_rdy   (data_rdy)
    );

    if_reg i_if_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .insn       (insn),
        .data_rdy   (data_rdy),
        .stall      (stall),
        .flush      (flush),
        .new_pc     (new_pc),
        .br_taken   (br_taken),
        .br_addr    (br_addr),
        .fetch_addr (fetch_addr),
        .consume    (consume),
        .if_pc_out  (if_pc_out),
        .if_insn    (if_insn),
        .if_en      (if_en)
    );

    id_decode i_id_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .kill         (kill),
        .if_pc_out    (if_pc_out),
        .if_insn      (if_insn),
        .if_en        (if_en),
        .id_pc        (id_pc),
        .id_op        (id_op),
        .id_rd        (id_rd),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_imm       (id_imm),
        .id_is_branch (id_is_branch),
        .id_illegal   (id_illegal),
        .id_valid     (id_valid)
    );

endmodule

// File: tests/tb_imem.sv
/*
 * Read-only Wishbone instruction memory model
 * Answers each classic read after 0 to 3 random wait states with a
 * word computed from the full address
 */

`timescale 1ns/1ns

module tb_imem (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  cpu_pkg::word_t  wb_adr,
    output cpu_pkg::word_t  wb_dat,
    output logic            wb_ack
);

    integer seed = 32'hf030;            // Wait state generator
    integer rnd;
    logic [1:0] wait_cnt;               // Wait states left in this request

    // Memory content, about one word in eight gets an illegal opcode
    function automatic cpu_pkg::word_t mem_word(input cpu_pkg::word_t addr);
        cpu_pkg::word_t h;
        cpu_pkg::op_t   op;
        h = addr * 32'h9e37_79b1;       // Mix every address bit
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        if (h[31:29] == 3'b000) op = {3'b001, h[28:26]};  // 8 to 15
        else                    op = {3'b000, h[28:26]};  // Legal 0 to 7
        return {op, h[25:0]};
    endfunction

    // Zero waits acks in the first strobe cycle
    assign wb_ack = wb_cyc && wb_stb && (wait_cnt == 2'd0);
    assign wb_dat = mem_word(wb_adr);

    always @(posedge clk) begin
        if (!rst_n) begin
            rnd = $random(seed);
            wait_cnt <= rnd[1:0];
        end else if (wb_cyc && wb_stb) begin
            if (wb_ack) begin
                rnd = $random(seed);    // Waits for the next request
                wait_cnt <= rnd[1:0];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: tests/tb_fetch.sv
/*
 * Testbench for the instruction front end
 * Random wait states, stalls and redirects; a reference decode of the
 * memory content is compared against every accepted decode output
 */

`timescale 1ns/1ns

module tb_fetch;

    localparam int N_INSN     = 400;    // Accepted outputs to see
    localparam int MAX_CYCLES = 5000;   // ~400 x 7 cycles plus stalls

    logic clk, rst_n, stall, flush, br_taken;
    cpu_pkg::word_t new_pc, br_addr;
    logic wb_cyc, wb_stb, wb_ack;
    cpu_pkg::word_t wb_adr, wb_dat;
    cpu_pkg::word_t id_pc, id_imm;
    cpu_pkg::op_t id_op;
    cpu_pkg::reg_idx_t id_rd, id_rs1, id_rs2;
    logic id_is_branch, id_illegal, id_valid;

    integer seed = 32'hf030;
    integer rnd;
    integer rnd_a;
    integer rnd_b;
    int accepted = 0;
    int cycles = 0;
    cpu_pkg::word_t exp_pc = cpu_pkg::RESET_VECTOR;
    logic rst_prev = 1'b0;              // Previous edge was in reset
    logic first_stb_seen = 1'b0;
    logic prev_stall = 1'b0;
    logic prev_kill = 1'b0;
    logic prev_valid;
    cpu_pkg::word_t snap_pc, snap_imm;  // Outputs before the last edge
    cpu_pkg::op_t snap_op;
    cpu_pkg::reg_idx_t snap_rd, snap_rs1, snap_rs2;
    logic snap_br, snap_ill;

    fetch_top i_fetch_top (.*);

    tb_imem i_imem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference decode straight from the ISA field layout
    function automatic void ref_decode(input cpu_pkg::word_t w, output cpu_pkg::op_t op,
                                       output cpu_pkg::reg_idx_t rd,
                                       output cpu_pkg::reg_idx_t rs1,
                                       output cpu_pkg::reg_idx_t rs2,
                                       output cpu_pkg::word_t imm,
                                       output logic br, output logic ill);
        op  = w[31:26];
        rd  = w[25:21];
        rs1 = w[20:16];
        rs2 = w[15:11];
        imm = {{16{w[15]}}, w[15:0]};
        br  = (op == 6'd5) || (op == 6'd6) || (op == 6'd7);
        ill = (op > 6'd7);
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_op(input string name, input cpu_pkg::op_t exp, input cpu_pkg::op_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input cpu_pkg::reg_idx_t exp,
                             input cpu_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Compare process, sees pre-edge values of the DUT
    always @(posedge clk) begin
        cpu_pkg::word_t w, e_imm;
        cpu_pkg::op_t e_op;
        cpu_pkg::reg_idx_t e_rd, e_rs1, e_rs2;
        logic e_br, e_ill;
        if (rst_prev) begin             // Outputs right after a reset edge
            check_bit("reset wb_cyc", 1'b0, wb_cyc);
            check_bit("reset wb_stb", 1'b0, wb_stb);
            check_bit("reset id_valid", 1'b0, id_valid);
        end
        rst_prev = !rst_n;
        if (rst_n) begin
            if (wb_stb && !first_stb_seen) begin
                check_word("first address", cpu_pkg::RESET_VECTOR, wb_adr);
                first_stb_seen = 1'b1;
            end
            if (prev_stall) begin       // Nothing may move under stall
                check_word("stall id_pc", snap_pc, id_pc);
                check_op("stall id_op", snap_op, id_op);
                check_reg("stall id_rd", snap_rd, id_rd);
                check_reg("stall id_rs1", snap_rs1, id_rs1);
                check_reg("stall id_rs2", snap_rs2, id_rs2);
                check_word("stall id_imm", snap_imm, id_imm);
                check_bit("stall id_is_branch", snap_br, id_is_branch);
                check_bit("stall id_illegal", snap_ill, id_illegal);
                if (!prev_kill) check_bit("stall id_valid", prev_valid, id_valid);
            end
            if (id_valid && !stall) begin
                w = i_imem.mem_word(exp_pc);
                ref_decode(w, e_op, e_rd, e_rs1, e_rs2, e_imm, e_br, e_ill);
                check_word("stream id_pc", exp_pc, id_pc);
                check_op("stream id_op", e_op, id_op);
                check_reg("stream id_rd", e_rd, id_rd);
                check_reg("stream id_rs1", e_rs1, id_rs1);
                check_reg("stream id_rs2", e_rs2, id_rs2);
                check_word("stream id_imm", e_imm, id_imm);
                check_bit("stream id_is_branch", e_br, id_is_branch);
                check_bit("illegal id_illegal", e_ill, id_illegal);
                exp_pc = exp_pc + cpu_pkg::INSN_STEP;
                accepted = accepted + 1;
            end
            if (flush) exp_pc = new_pc;             // Flush wins
            else if (br_taken) exp_pc = br_addr;
            prev_stall = stall;
            prev_kill  = flush | br_taken;
            prev_valid = id_valid;
            snap_pc  = id_pc;
            snap_op  = id_op;
            snap_rd  = id_rd;
            snap_rs1 = id_rs1;
            snap_rs2 = id_rs2;
            snap_imm = id_imm;
            snap_br  = id_is_branch;
            snap_ill = id_illegal;
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: decode stream stopped before all instructions were seen");
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // Stimulus on the falling edge
    initial begin
        rst_n    = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        br_taken = 1'b0;
        new_pc   = '0;
        br_addr  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (accepted < N_INSN) begin
            @(negedge clk);
            rnd   = $random(seed);
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            flush    = 1'b0;                        // Pulses last one cycle
            br_taken = 1'b0;
            stall    = (accepted >= 100) && (rnd[2:0] == 3'd0);
            if (accepted >= 200 && rnd[10:5] == 6'd0) begin
                new_pc   = rnd_a & 32'h0003_fffc;   // Word aligned targets
                br_addr  = rnd_b & 32'h0003_fffc;
                flush    = (rnd[12:11] == 2'd0) || (rnd[12:11] == 2'd2);
                br_taken = (rnd[12:11] != 2'd0);
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb.f
rtl/cpu_pkg.sv
rtl/if_fetch.sv
rtl/if_reg.sv
rtl/id_decode.sv
rtl/fetch_top.sv
tests/tb_imem.sv
tests/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_fetch -o sim_fetch

# The log decides the result, so a failing run must not stop the script here
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
